// ==== rackbus_pkg.sv ====
package rackbus_pkg;

    // field widths of the rack-bus command word
    localparam int RUNCMD_BITS = 2;
    localparam int TRIG_BITS   = 15;

    // run command codes
    localparam logic [RUNCMD_BITS-1:0] RUNCMD_NOOP = 2'd0;

    // mode1 type codes
    localparam logic [1:0] MODE1_SPECIAL = 2'd0;
    localparam logic [1:0] MODE1_FWU     = 2'd1;

    // special mode1 data codes, meaningful only with MODE1_SPECIAL
    localparam logic [7:0] MODE1_NOOP      = 8'h00;
    localparam logic [7:0] MODE1_MARK0_FWU = 8'h01;
    localparam logic [7:0] MODE1_MARK1_FWU = 8'h02;

    // counter values compared one cycle ahead of each strobe
    // precapture is then high in phase 6, capture in phase 7
    localparam logic [2:0] PRECAPTURE_PHASE = 3'd5;
    localparam logic [2:0] CAPTURE_PHASE    = 3'd6;

    // command word, msb first
    typedef struct packed {
        // nothing in the word is meaningful
        logic                   ignore;
        logic                   pps;
        logic [RUNCMD_BITS-1:0] runcmd;
        logic [1:0]             mode1type;
        logic [7:0]             mode1data;
        // always zero on output
        logic [1:0]             reserved;
        logic                   trig_valid;
        logic [TRIG_BITS-1:0]   trig;
    } rackbus_cmd_t;

endpackage

// ==== mode1_stream_if.sv ====
`timescale 1ns/1ns
interface mode1_stream_if;

    // stream byte
    logic [7:0] tdata;
    // mode1 type carried with the byte
    logic [1:0] tuser;
    logic       tvalid;
    // one-cycle acknowledge, the byte went out on the bus
    logic       tready;

    // side that queues mode1 bytes
    modport source (
        output tdata, tuser, tvalid,
        input  tready
    );

    // side that captures and acknowledges
    modport sink (
        input  tdata, tuser, tvalid,
        output tready
    );

endinterface

// ==== cmd_phase_gen.sv ====
`timescale 1ns/1ns
module cmd_phase_gen (
    input  logic sysclk_i,
    input  logic rst_i,
    input  logic sync_i,
    output logic precapture_o,
    output logic capture_o
);
    import rackbus_pkg::*;

    // position inside the 8-cycle command frame
    logic [2:0] phase;

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            phase <= 3'd0;
        end else if (sync_i) begin
            // sync cycle counts as phase 0 of the new frame
            phase <= 3'd1;
        end else begin
            // wraps modulo 8 on its own
            phase <= phase + 3'd1;
        end
    end

    // registered compares give clean one-cycle strobes
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            precapture_o <= 1'b0;
            capture_o    <= 1'b0;
        end else begin
            precapture_o <= (phase == PRECAPTURE_PHASE);
            capture_o    <= (phase == CAPTURE_PHASE);
        end
    end

endmodule

// ==== tfio_cmd_holding.sv ====
`timescale 1ns/1ns
module tfio_cmd_holding (
    input  logic                               sysclk_i,
    input  logic                               rst_i,
    input  logic                               precapture_i,
    input  logic                               capture_i,
    mode1_stream_if.sink                       mode1,
    input  logic [7:0]                         fw_tdata_i,
    input  logic                               fw_tvalid_i,
    output logic                               fw_tready_o,
    input  logic [1:0]                         fw_mark_i,
    output logic                               fw_marked_o,
    input  logic [rackbus_pkg::RUNCMD_BITS-1:0] runcmd_tdata_i,
    input  logic                               runcmd_tvalid_i,
    output logic                               runcmd_tready_o,
    input  logic                               mode1_free_i,
    input  logic                               runcmd_free_i,
    output logic [7:0]                         held_mode1data_o,
    output logic [1:0]                         held_mode1type_o,
    output logic [rackbus_pkg::RUNCMD_BITS-1:0] held_runcmd_o,
    output logic                               has_data_o
);
    import rackbus_pkg::*;

    // candidate mode1 field for the next capture
    logic [7:0] mode1data_next;
    logic [1:0] mode1type_next;
    logic       hold_mode1_next;
    logic       hold_mark_next;
    logic       hold_fwu_next;

    // which source the held mode1 field came from
    // at most one of these is set
    logic hold_mode1;
    logic hold_mark;
    logic hold_fwu;
    logic hold_runcmd;

    // one-cycle acks, high the cycle after capture
    logic mode1_ack;
    logic fw_ack;
    logic mark_ack;
    logic runcmd_ack;

    // priority: stream, mark 0, mark 1, firmware byte, then noop
    always_comb begin
        mode1data_next  = MODE1_NOOP;
        mode1type_next  = MODE1_SPECIAL;
        hold_mode1_next = 1'b0;
        hold_mark_next  = 1'b0;
        hold_fwu_next   = 1'b0;
        if (mode1.tvalid) begin
            mode1data_next  = mode1.tdata;
            mode1type_next  = mode1.tuser;
            hold_mode1_next = 1'b1;
        end else if (fw_mark_i[0]) begin
            mode1data_next = MODE1_MARK0_FWU;
            hold_mark_next = 1'b1;
        end else if (fw_mark_i[1]) begin
            mode1data_next = MODE1_MARK1_FWU;
            hold_mark_next = 1'b1;
        end else if (fw_tvalid_i) begin
            mode1data_next = fw_tdata_i;
            mode1type_next = MODE1_FWU;
            hold_fwu_next  = 1'b1;
        end
    end

    // everything reloads each frame, a skipped item is simply recaptured
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            held_mode1data_o <= MODE1_NOOP;
            held_mode1type_o <= MODE1_SPECIAL;
            held_runcmd_o    <= RUNCMD_NOOP;
            hold_mode1       <= 1'b0;
            hold_mark        <= 1'b0;
            hold_fwu         <= 1'b0;
            hold_runcmd      <= 1'b0;
        end else if (precapture_i) begin
            held_mode1data_o <= mode1data_next;
            held_mode1type_o <= mode1type_next;
            held_runcmd_o    <= runcmd_tvalid_i ? runcmd_tdata_i : RUNCMD_NOOP;
            hold_mode1       <= hold_mode1_next;
            hold_mark        <= hold_mark_next;
            hold_fwu         <= hold_fwu_next;
            hold_runcmd      <= runcmd_tvalid_i;
        end
    end

    // ack only what the splice actually put on the bus
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            mode1_ack  <= 1'b0;
            fw_ack     <= 1'b0;
            mark_ack   <= 1'b0;
            runcmd_ack <= 1'b0;
        end else begin
            mode1_ack  <= capture_i && hold_mode1 && mode1_free_i;
            fw_ack     <= capture_i && hold_fwu && mode1_free_i;
            mark_ack   <= capture_i && hold_mark && mode1_free_i;
            runcmd_ack <= capture_i && hold_runcmd && runcmd_free_i;
        end
    end

    assign mode1.tready    = mode1_ack;
    assign fw_tready_o     = fw_ack;
    assign fw_marked_o     = mark_ack;
    assign runcmd_tready_o = runcmd_ack;

    // pps is added by the splice block
    assign has_data_o = hold_mode1 || hold_mark || hold_fwu || hold_runcmd;

endmodule

// ==== cmd_word_splice.sv ====
`timescale 1ns/1ns
module cmd_word_splice (
    input  logic                               sysclk_i,
    input  logic                               rst_i,
    input  logic                               capture_i,
    input  rackbus_pkg::rackbus_cmd_t          command_i,
    input  logic                               command_locked_i,
    input  logic                               tfio_pps_i,
    input  logic                               use_tfio_pps_i,
    input  logic [rackbus_pkg::TRIG_BITS-1:0]  trig_tdata_i,
    input  logic                               trig_tvalid_i,
    input  logic [7:0]                         held_mode1data_i,
    input  logic [1:0]                         held_mode1type_i,
    input  logic [rackbus_pkg::RUNCMD_BITS-1:0] held_runcmd_i,
    input  logic                               has_data_i,
    output logic                               mode1_free_o,
    output logic                               runcmd_free_o,
    output rackbus_pkg::rackbus_cmd_t          spliced_o
);
    import rackbus_pkg::*;

    // upstream word carries nothing at all
    logic turf_empty;
    logic mode1_free;
    logic runcmd_free;
    // local pps stretched until the next capture
    logic tfio_pps_seen;
    logic tfio_pps;
    logic turf_pps;
    logic local_data;
    logic turf_trig_valid;

    assign turf_empty = !command_locked_i || command_i.ignore;

    // mode1 field is free unless upstream sends exactly special/noop
    assign mode1_free = turf_empty ||
                        (command_i.mode1type != MODE1_SPECIAL) ||
                        (command_i.mode1data != MODE1_NOOP);
    assign runcmd_free = turf_empty || (command_i.runcmd == RUNCMD_NOOP);

    assign mode1_free_o  = mode1_free;
    assign runcmd_free_o = runcmd_free;

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            tfio_pps_seen <= 1'b0;
        end else if (capture_i) begin
            tfio_pps_seen <= 1'b0;
        end else if (tfio_pps_i) begin
            tfio_pps_seen <= 1'b1;
        end
    end

    // a pulse in the capture cycle itself still goes out
    assign tfio_pps = tfio_pps_i || tfio_pps_seen;
    assign turf_pps = command_i.pps && !turf_empty;

    // anything local forces ignore low
    assign local_data = has_data_i || (tfio_pps && use_tfio_pps_i);

    // upstream trigger only counts when the link is locked
    assign turf_trig_valid = command_locked_i && command_i.trig_valid;

    always_comb begin
        spliced_o            = '0;
        spliced_o.ignore     = turf_empty && !local_data;
        spliced_o.pps        = use_tfio_pps_i ? tfio_pps : turf_pps;
        spliced_o.runcmd     = runcmd_free ? held_runcmd_i : command_i.runcmd;
        spliced_o.mode1type  = mode1_free ? held_mode1type_i : command_i.mode1type;
        spliced_o.mode1data  = mode1_free ? held_mode1data_i : command_i.mode1data;
        spliced_o.trig_valid = turf_trig_valid || trig_tvalid_i;
        spliced_o.trig       = turf_trig_valid ? command_i.trig : trig_tdata_i;
    end

endmodule

// ==== turfio_cmd_splice_top.sv ====
`timescale 1ns/1ns
module turfio_cmd_splice_top (
    input  logic                               sysclk_i,
    input  logic                               rst_i,
    input  logic                               sync_i,
    input  logic                               command_locked_i,
    input  logic                               use_tfio_pps_i,
    input  logic                               tfio_pps_i,
    input  logic [31:0]                        command_i,
    input  logic [7:0]                         mode1_tdata_i,
    input  logic [1:0]                         mode1_tuser_i,
    input  logic                               mode1_tvalid_i,
    output logic                               mode1_tready_o,
    input  logic [7:0]                         fw_tdata_i,
    input  logic                               fw_tvalid_i,
    output logic                               fw_tready_o,
    input  logic [1:0]                         fw_mark_i,
    output logic                               fw_marked_o,
    input  logic [rackbus_pkg::RUNCMD_BITS-1:0] runcmd_tdata_i,
    input  logic                               runcmd_tvalid_i,
    output logic                               runcmd_tready_o,
    input  logic [rackbus_pkg::TRIG_BITS-1:0]  trig_tdata_i,
    input  logic                               trig_tvalid_i,
    output logic                               trig_tready_o,
    output logic [31:0]                        spliced_o
);
    import rackbus_pkg::*;

    logic                   precapture;
    logic                   capture;
    logic                   mode1_free;
    logic                   runcmd_free;
    logic [7:0]             held_mode1data;
    logic [1:0]             held_mode1type;
    logic [RUNCMD_BITS-1:0] held_runcmd;
    logic                   has_data;
    rackbus_cmd_t           command;
    rackbus_cmd_t           spliced;

    mode1_stream_if mode1_bus ();

    // plain mode1 ports onto the stream bundle
    assign mode1_bus.tdata  = mode1_tdata_i;
    assign mode1_bus.tuser  = mode1_tuser_i;
    assign mode1_bus.tvalid = mode1_tvalid_i;
    assign mode1_tready_o   = mode1_bus.tready;

    assign command   = command_i;
    assign spliced_o = spliced;

    // local trigger is never acknowledged
    assign trig_tready_o = 1'b0;

    cmd_phase_gen u_phase (
        .sysclk_i     (sysclk_i),
        .rst_i        (rst_i),
        .sync_i       (sync_i),
        .precapture_o (precapture),
        .capture_o    (capture)
    );

    tfio_cmd_holding u_holding (
        .sysclk_i         (sysclk_i),
        .rst_i            (rst_i),
        .precapture_i     (precapture),
        .capture_i        (capture),
        .mode1            (mode1_bus.sink),
        .fw_tdata_i       (fw_tdata_i),
        .fw_tvalid_i      (fw_tvalid_i),
        .fw_tready_o      (fw_tready_o),
        .fw_mark_i        (fw_mark_i),
        .fw_marked_o      (fw_marked_o),
        .runcmd_tdata_i   (runcmd_tdata_i),
        .runcmd_tvalid_i  (runcmd_tvalid_i),
        .runcmd_tready_o  (runcmd_tready_o),
        .mode1_free_i     (mode1_free),
        .runcmd_free_i    (runcmd_free),
        .held_mode1data_o (held_mode1data),
        .held_mode1type_o (held_mode1type),
        .held_runcmd_o    (held_runcmd),
        .has_data_o       (has_data)
    );

    cmd_word_splice u_splice (
        .sysclk_i         (sysclk_i),
        .rst_i            (rst_i),
        .capture_i        (capture),
        .command_i        (command),
        .command_locked_i (command_locked_i),
        .tfio_pps_i       (tfio_pps_i),
        .use_tfio_pps_i   (use_tfio_pps_i),
        .trig_tdata_i     (trig_tdata_i),
        .trig_tvalid_i    (trig_tvalid_i),
        .held_mode1data_i (held_mode1data),
        .held_mode1type_i (held_mode1type),
        .held_runcmd_i    (held_runcmd),
        .has_data_i       (has_data),
        .mode1_free_o     (mode1_free),
        .runcmd_free_o    (runcmd_free),
        .spliced_o        (spliced)
    );

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ns
module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 16;

    // free-running clock, 20 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // reset held for a fixed number of rising edges
    // released on a falling edge like every other input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== tb_turfio_cmd_splice.sv ====
`timescale 1ns/1ns
module tb_turfio_cmd_splice;
    import rackbus_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_FRAMES   = 40;
    // twice the longest run the tests can take
    localparam int TIMEOUT_NS   = 2 * (RESET_CYCLES + MAX_FRAMES * 8) * CLK_PERIOD;

    logic                   sysclk;
    logic                   rst;
    logic                   sync;
    logic                   command_locked;
    logic                   use_tfio_pps;
    logic                   tfio_pps;
    rackbus_cmd_t           command;
    logic [7:0]             mode1_tdata;
    logic [1:0]             mode1_tuser;
    logic                   mode1_tvalid;
    logic                   mode1_tready;
    logic [7:0]             fw_tdata;
    logic                   fw_tvalid;
    logic                   fw_tready;
    logic [1:0]             fw_mark;
    logic                   fw_marked;
    logic [RUNCMD_BITS-1:0] runcmd_tdata;
    logic                   runcmd_tvalid;
    logic                   runcmd_tready;
    logic [TRIG_BITS-1:0]   trig_tdata;
    logic                   trig_tvalid;
    logic                   trig_tready;
    rackbus_cmd_t           spliced;

    integer seed;
    int     error_count;

    tb_clkgen u_clkgen (
        .clk_o (sysclk),
        .rst_o (rst)
    );

    turfio_cmd_splice_top dut (
        .sysclk_i         (sysclk),
        .rst_i            (rst),
        .sync_i           (sync),
        .command_locked_i (command_locked),
        .use_tfio_pps_i   (use_tfio_pps),
        .tfio_pps_i       (tfio_pps),
        .command_i        (command),
        .mode1_tdata_i    (mode1_tdata),
        .mode1_tuser_i    (mode1_tuser),
        .mode1_tvalid_i   (mode1_tvalid),
        .mode1_tready_o   (mode1_tready),
        .fw_tdata_i       (fw_tdata),
        .fw_tvalid_i      (fw_tvalid),
        .fw_tready_o      (fw_tready),
        .fw_mark_i        (fw_mark),
        .fw_marked_o      (fw_marked),
        .runcmd_tdata_i   (runcmd_tdata),
        .runcmd_tvalid_i  (runcmd_tvalid),
        .runcmd_tready_o  (runcmd_tready),
        .trig_tdata_i     (trig_tdata),
        .trig_tvalid_i    (trig_tvalid),
        .trig_tready_o    (trig_tready),
        .spliced_o        (spliced)
    );

    // builds a command word field by field, reserved bits zero
    function automatic rackbus_cmd_t pack_cmd(
        input logic                   ignore,
        input logic                   pps,
        input logic [RUNCMD_BITS-1:0] runcmd,
        input logic [1:0]             mode1type,
        input logic [7:0]             mode1data,
        input logic                   trig_valid,
        input logic [TRIG_BITS-1:0]   trig
    );
        rackbus_cmd_t w;
        w            = '0;
        w.ignore     = ignore;
        w.pps        = pps;
        w.runcmd     = runcmd;
        w.mode1type  = mode1type;
        w.mode1data  = mode1data;
        w.trig_valid = trig_valid;
        w.trig       = trig;
        return w;
    endfunction

    // ack order: mode1, fw byte, fw mark, run command
    function automatic logic [3:0] current_acks();
        return {mode1_tready, fw_tready, fw_marked, runcmd_tready};
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        if (got !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // called on a falling edge, returns on the falling edge of the capture cycle
    task automatic sync_frame();
        sync = 1'b1;
        @(negedge sysclk);
        sync = 1'b0;
        // phase 1 now, capture comes with phase 7
        repeat (6) @(negedge sysclk);
    endtask

    // one frame: output word at capture, then acks in the following cycle
    task automatic run_frame(input rackbus_cmd_t expected, input logic [3:0] exp_acks);
        sync_frame();
        check_value("spliced_o", spliced, expected);
        check_value("{mode1_tready,fw_tready,fw_marked,runcmd_tready}", current_acks(), 4'b0);
        @(negedge sysclk);
        check_value("{mode1_tready,fw_tready,fw_marked,runcmd_tready}", current_acks(), exp_acks);
    endtask

    task automatic test_unlocked_idle();
        command_locked = 1'b0;
        // upstream content is meaningless while unlocked
        command = $random(seed);
        run_frame(pack_cmd(1'b1, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0),
                  4'b0000);
    endtask

    task automatic test_mode1_priority();
        logic [7:0] stream_byte;
        logic [7:0] fw_byte;
        stream_byte    = $random(seed);
        fw_byte        = $random(seed);
        command_locked = 1'b0;
        command        = '0;
        mode1_tdata    = stream_byte;
        mode1_tuser    = 2'd2;
        mode1_tvalid   = 1'b1;
        fw_mark        = 2'b01;
        fw_tdata       = fw_byte;
        fw_tvalid      = 1'b1;
        // stream beats marks and firmware bytes
        run_frame(pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, 2'd2, stream_byte, 1'b0, '0), 4'b1000);
        mode1_tvalid = 1'b0;
        run_frame(pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_MARK0_FWU, 1'b0, '0),
                  4'b0010);
        fw_mark = 2'b10;
        run_frame(pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_MARK1_FWU, 1'b0, '0),
                  4'b0010);
        fw_mark = 2'b00;
        run_frame(pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_FWU, fw_byte, 1'b0, '0), 4'b0100);
        fw_tvalid = 1'b0;
        // queue empty again
        run_frame(pack_cmd(1'b1, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0),
                  4'b0000);
    endtask

    task automatic test_backpressure();
        logic [7:0] stream_byte;
        stream_byte    = $random(seed);
        command_locked = 1'b1;
        mode1_tdata    = stream_byte;
        mode1_tuser    = 2'd3;
        mode1_tvalid   = 1'b1;
        // special/noop upstream keeps the mode1 field, nothing is acked
        command = pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0);
        run_frame(pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0),
                  4'b0000);
        // any other upstream mode1 content leaves the field to the held byte
        command = pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_FWU, 8'h5a, 1'b0, '0);
        run_frame(pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, 2'd3, stream_byte, 1'b0, '0), 4'b1000);
        mode1_tvalid = 1'b0;
    endtask

    task automatic test_runcmd();
        command_locked = 1'b1;
        command        = pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0);
        runcmd_tdata   = 2'd2;
        runcmd_tvalid  = 1'b1;
        run_frame(pack_cmd(1'b0, 1'b0, 2'd2, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0), 4'b0001);
        // next item queued while upstream owns the field
        runcmd_tdata = 2'd1;
        command      = pack_cmd(1'b0, 1'b0, 2'd3, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0);
        run_frame(pack_cmd(1'b0, 1'b0, 2'd3, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0), 4'b0000);
        command = pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0);
        run_frame(pack_cmd(1'b0, 1'b0, 2'd1, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0), 4'b0001);
        runcmd_tvalid = 1'b0;
    endtask

    task automatic test_pps();
        command_locked = 1'b0;
        command        = '0;
        use_tfio_pps   = 1'b1;
        // single-cycle local pulse well before capture
        tfio_pps = 1'b1;
        @(negedge sysclk);
        tfio_pps = 1'b0;
        run_frame(pack_cmd(1'b0, 1'b1, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0),
                  4'b0000);
        // capture has cleared the latch
        check_value("spliced_o",
                    spliced,
                    pack_cmd(1'b1, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0));
        // upstream pps selected, local pulse has no effect
        use_tfio_pps   = 1'b0;
        command_locked = 1'b1;
        command        = pack_cmd(1'b0, 1'b1, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0);
        tfio_pps       = 1'b1;
        @(negedge sysclk);
        tfio_pps = 1'b0;
        run_frame(pack_cmd(1'b0, 1'b1, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0),
                  4'b0000);
        // ignored upstream word drops its pps
        // an unselected local pulse neither sets pps nor clears ignore
        command  = pack_cmd(1'b1, 1'b1, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0);
        tfio_pps = 1'b1;
        @(negedge sysclk);
        tfio_pps = 1'b0;
        run_frame(pack_cmd(1'b1, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP, 1'b0, '0),
                  4'b0000);
    endtask

    task automatic test_trigger();
        int                   i;
        int                   rnd;
        logic                 up_wins;
        logic                 exp_valid;
        logic [TRIG_BITS-1:0] up_trig;
        logic [TRIG_BITS-1:0] exp_trig;
        for (i = 0; i < 16; i++) begin
            rnd            = $random(seed);
            up_trig        = $random(seed);
            trig_tdata     = $random(seed);
            command_locked = rnd[0];
            trig_tvalid    = rnd[1];
            command        = pack_cmd(1'b0, 1'b0, RUNCMD_NOOP, MODE1_SPECIAL, MODE1_NOOP,
                                      rnd[2], up_trig);
            // locked upstream trigger wins, otherwise local passes straight through
            up_wins   = rnd[0] && rnd[2];
            exp_valid = up_wins || rnd[1];
            exp_trig  = up_wins ? up_trig : trig_tdata;
            #(CLK_PERIOD / 4);
            check_value("spliced_o.trig_valid", spliced.trig_valid, exp_valid);
            check_value("spliced_o.trig", spliced.trig, exp_trig);
            check_value("trig_tready_o", trig_tready, 1'b0);
            @(negedge sysclk);
        end
        trig_tdata  = '0;
        trig_tvalid = 1'b0;
    endtask

    initial begin
        seed           = 72781;
        error_count    = 0;
        sync           = 1'b0;
        command_locked = 1'b0;
        use_tfio_pps   = 1'b0;
        tfio_pps       = 1'b0;
        command        = '0;
        mode1_tdata    = '0;
        mode1_tuser    = '0;
        mode1_tvalid   = 1'b0;
        fw_tdata       = '0;
        fw_tvalid      = 1'b0;
        fw_mark        = '0;
        runcmd_tdata   = '0;
        runcmd_tvalid  = 1'b0;
        trig_tdata     = '0;
        trig_tvalid    = 1'b0;
        @(negedge rst);
        @(negedge sysclk);
        test_unlocked_idle();
        test_mode1_priority();
        test_backpressure();
        test_runcmd();
        test_pps();
        test_trigger();
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== all.f ====
rackbus_pkg.sv
mode1_stream_if.sv
cmd_phase_gen.sv
tfio_cmd_holding.sv
cmd_word_splice.sv
turfio_cmd_splice_top.sv
tb_clkgen.sv
tb_turfio_cmd_splice.sv

// ==== Bender.yml ====
package:
  name: turfio_cmd_splice

sources:
  - files:
      - rackbus_pkg.sv
      - mode1_stream_if.sv
      - cmd_phase_gen.sv
      - tfio_cmd_holding.sv
      - cmd_word_splice.sv
      - turfio_cmd_splice_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_turfio_cmd_splice.sv
